// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rob_top_tb
FILE_LIST ?= rob_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Done: no errors

SOURCES := $(shell cat $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== rob_top.f ====
source/rob_config_pkg.sv
source/rob_pipe_pkg.sv
source/rob_pointers.sv
source/rob_entry_table.sv
source/rob_retire_select.sv
source/rob_top.sv
testbench/rob_top_assertions.sv
testbench/rob_top_tb.sv

// ==== source/rob_config_pkg.sv ====
`default_nettype none

package rob_config_pkg;

	////////////////////
	// buffer sizes
	////////////////////

	localparam int rob_depth_default = 64;	// must stay a power of two
	localparam int cdb_lanes_default = 6;	// result broadcast lanes

	////////////////////
	// register naming
	////////////////////

	typedef logic [6:0] phys_tag_t;	// physical register tag
	typedef logic [4:0] arch_reg_t;	// architectural register index

	localparam phys_tag_t no_tag = '1;	// empty slot, never broadcast

	////////////////////
	// stored entry
	////////////////////

	typedef struct packed
	{
		logic      valid;	// slot holds an instruction
		logic      ready;	// result written or nothing to wait for
		logic      exception;	// set by the completing lane
		logic      halt;
		logic      wr_mem;	// store
		phys_tag_t tag;
		arch_reg_t arch_reg;
	} rob_entry_t;

endpackage

`default_nettype wire

// ==== source/rob_entry_table.sv ====
`default_nettype none

module rob_entry_table
#(
	parameter int rob_depth = rob_config_pkg::rob_depth_default,
	parameter int cdb_lanes = rob_config_pkg::cdb_lanes_default
)
(
	input  wire                              clock,
	input  wire                              reset,
	input  wire [$clog2(rob_depth)-1:0]      head,
	input  wire [$clog2(rob_depth)-1:0]      tail,
	input  wire rob_pipe_pkg::issue_count_t   dispatch_num,
	input  wire rob_pipe_pkg::dispatch_slot_t dispatch [2],
	input  wire rob_pipe_pkg::complete_lane_t complete [cdb_lanes],
	input  wire rob_pipe_pkg::issue_count_t   retire_num,
	output rob_config_pkg::rob_entry_t       head_entry,
	output rob_config_pkg::rob_entry_t       next_entry
);

	import rob_config_pkg::*;
	import rob_pipe_pkg::*;

	localparam int ptr_bits = $clog2(rob_depth);

	rob_entry_t entries      [rob_depth];
	rob_entry_t next_entries [rob_depth];

	logic [ptr_bits-1:0] head_plus_one;
	logic [ptr_bits-1:0] tail_plus_one;

	assign head_plus_one = head + ptr_bits'(1);
	assign tail_plus_one = tail + ptr_bits'(1);

	// record built from one dispatched slot
	function automatic rob_entry_t new_entry(input dispatch_slot_t slot);
		rob_entry_t entry;
		entry.valid     = 1'b1;
		entry.ready     = ~slot.valid_inst | slot.halt;	// nothing to wait for
		entry.exception = 1'b0;
		entry.halt      = slot.halt;
		entry.wr_mem    = slot.wr_mem;
		entry.tag       = slot.tag;
		entry.arch_reg  = slot.arch_reg;
		return entry;
	endfunction

	always_comb
	begin
		next_entries = entries;

		////////////////////
		// dispatch
		////////////////////
		if (dispatch_num != 2'd0)
		begin
			next_entries[tail] = new_entry(dispatch[0]);
		end
		if (dispatch_num == 2'd2)
		begin
			next_entries[tail_plus_one] = new_entry(dispatch[1]);
		end

		////////////////////
		// completion
		////////////////////
		// later lanes overwrite earlier ones on a shared tag
		for (int l = 0; l < cdb_lanes; l++)
		begin
			if (complete[l].valid)
			begin
				for (int i = 0; i < rob_depth; i++)
				begin
					if (entries[i].valid && entries[i].tag == complete[l].tag)
					begin
						next_entries[i].ready     = 1'b1;
						next_entries[i].exception = complete[l].exception;
					end
				end
			end
		end

		////////////////////
		// retirement
		////////////////////
		if (retire_num != 2'd0)
		begin
			next_entries[head].valid = 1'b0;
			next_entries[head].ready = 1'b0;
			next_entries[head].tag   = no_tag;	// keeps stale tags off the match
		end
		if (retire_num == 2'd2)
		begin
			next_entries[head_plus_one].valid = 1'b0;
			next_entries[head_plus_one].ready = 1'b0;
			next_entries[head_plus_one].tag   = no_tag;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < rob_depth; i++)
			begin
				entries[i].valid <= 1'b0;
				entries[i].ready <= 1'b0;
				entries[i].tag   <= no_tag;
			end
		end
		else
		begin
			entries <= next_entries;
		end
	end

	assign head_entry = entries[head];	// oldest
	assign next_entry = entries[head_plus_one];	// second oldest

endmodule

`default_nettype wire

// ==== source/rob_pipe_pkg.sv ====
`default_nettype none

package rob_pipe_pkg;

	import rob_config_pkg::*;

	// 0, 1 or 2 instructions per cycle
	typedef logic [1:0] issue_count_t;

	////////////////////
	// dispatch side
	////////////////////

	typedef struct packed
	{
		phys_tag_t tag;	// destination physical tag
		arch_reg_t arch_reg;	// destination architectural register
		logic      valid_inst;	// low for a bubble
		logic      halt;
		logic      wr_mem;	// store
	} dispatch_slot_t;

	////////////////////
	// broadcast bus
	////////////////////

	typedef struct packed
	{
		logic      valid;
		phys_tag_t tag;	// tag of the finished result
		logic      exception;
	} complete_lane_t;

	////////////////////
	// retire side
	////////////////////

	typedef struct packed
	{
		phys_tag_t tag;	// freed by the map table and free list
		arch_reg_t arch_reg;
		logic      wr_mem;	// lets the store queue commit
	} retire_slot_t;

endpackage

`default_nettype wire

// ==== source/rob_pointers.sv ====
`default_nettype none

module rob_pointers
#(
	parameter int rob_depth = rob_config_pkg::rob_depth_default
)
(
	input  wire                         clock,
	input  wire                         reset,
	input  wire rob_pipe_pkg::issue_count_t dispatch_num,
	input  wire rob_pipe_pkg::issue_count_t retire_num,
	output logic [$clog2(rob_depth)-1:0] head,
	output logic [$clog2(rob_depth)-1:0] tail,
	output rob_pipe_pkg::issue_count_t   capacity
);

	localparam int ptr_bits = $clog2(rob_depth);
	localparam int cnt_bits = ptr_bits + 1;	// must also hold rob_depth itself

	logic [cnt_bits-1:0] count;	// entries in flight
	logic [cnt_bits-1:0] free;

	////////////////////
	// pointer state
	////////////////////

	// depth is a power of two, so the pointers wrap by overflow
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			head  <= head + ptr_bits'(retire_num);	// oldest entry
			tail  <= tail + ptr_bits'(dispatch_num);	// next free slot
			count <= count + cnt_bits'(dispatch_num) - cnt_bits'(retire_num);
		end
	end

	////////////////////
	// dispatch capacity
	////////////////////

	assign free = cnt_bits'(rob_depth) - count;

	// same-cycle retirement is not counted
	always_comb
	begin
		if (free >= cnt_bits'(2))
		begin
			capacity = 2'd2;
		end
		else
		begin
			capacity = free[1:0];	// 0 or 1 slot left
		end
	end

endmodule

`default_nettype wire

// ==== source/rob_retire_select.sv ====
`default_nettype none

module rob_retire_select
(
	input  wire rob_config_pkg::rob_entry_t head_entry,
	input  wire rob_config_pkg::rob_entry_t next_entry,
	output rob_pipe_pkg::issue_count_t     retire_num,
	output rob_pipe_pkg::retire_slot_t     retire [2],
	output logic                           retire_halt,
	output logic                           recover_exception
);

	logic retire_pair;	// both oldest entries leave together
	logic store_pair;

	assign store_pair  = head_entry.wr_mem & next_entry.wr_mem;	// one store port
	assign retire_pair = head_entry.ready & next_entry.ready
		& ~head_entry.exception & ~store_pair;

	always_comb
	begin
		if (retire_pair)
		begin
			retire_num  = 2'd2;
			retire_halt = head_entry.halt | next_entry.halt;
		end
		else if (head_entry.ready)
		begin
			retire_num  = 2'd1;	// exception, store pair or younger not done
			retire_halt = head_entry.halt;
		end
		else
		begin
			retire_num  = 2'd0;
			retire_halt = 1'b0;
		end
	end

	// signal only, younger entries stay in place
	assign recover_exception = head_entry.ready
		& (head_entry.exception | (next_entry.ready & next_entry.exception));

	// qualified by retire_num downstream
	assign retire[0] = '{tag: head_entry.tag, arch_reg: head_entry.arch_reg,
		wr_mem: head_entry.wr_mem};
	assign retire[1] = '{tag: next_entry.tag, arch_reg: next_entry.arch_reg,
		wr_mem: next_entry.wr_mem};

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`default_nettype none

module rob_top
#(
	parameter int rob_depth = rob_config_pkg::rob_depth_default,
	parameter int cdb_lanes = rob_config_pkg::cdb_lanes_default
)
(
	input  wire                              clock,
	input  wire                              reset,
	input  wire rob_pipe_pkg::issue_count_t   dispatch_num,
	input  wire rob_pipe_pkg::dispatch_slot_t dispatch [2],
	input  wire rob_pipe_pkg::complete_lane_t complete [cdb_lanes],
	output rob_pipe_pkg::issue_count_t       capacity,
	output rob_pipe_pkg::issue_count_t       retire_num,
	output rob_pipe_pkg::retire_slot_t       retire [2],
	output logic                             retire_halt,
	output logic                             recover_exception
);

	import rob_config_pkg::*;

	localparam int ptr_bits = $clog2(rob_depth);

	logic [ptr_bits-1:0] head;
	logic [ptr_bits-1:0] tail;
	rob_entry_t          head_entry;
	rob_entry_t          next_entry;

	rob_pointers #(.rob_depth(rob_depth)) pointers_inst
	(
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.retire_num   (retire_num),
		.head         (head),
		.tail         (tail),
		.capacity     (capacity)
	);

	rob_entry_table #(.rob_depth(rob_depth), .cdb_lanes(cdb_lanes)) entry_table_inst
	(
		.clock        (clock),
		.reset        (reset),
		.head         (head),
		.tail         (tail),
		.dispatch_num (dispatch_num),
		.dispatch     (dispatch),
		.complete     (complete),
		.retire_num   (retire_num),
		.head_entry   (head_entry),
		.next_entry   (next_entry)
	);

	// combinational, takes effect at the next edge
	rob_retire_select retire_select_inst
	(
		.head_entry        (head_entry),
		.next_entry        (next_entry),
		.retire_num        (retire_num),
		.retire            (retire),
		.retire_halt       (retire_halt),
		.recover_exception (recover_exception)
	);

endmodule

`default_nettype wire

// ==== testbench/rob_top_assertions.sv ====
`default_nettype none

module rob_top_assertions
(
	input wire                              clock,
	input wire                              reset,
	input wire rob_pipe_pkg::issue_count_t  dispatch_num,
	input wire rob_pipe_pkg::issue_count_t  capacity,
	input wire rob_pipe_pkg::issue_count_t  retire_num,
	input wire rob_pipe_pkg::retire_slot_t  retire [2]
);

	dispatch_within_capacity : assert property (@(posedge clock) disable iff (reset)
		dispatch_num <= capacity)	// never overrun free slots
		else $error("dispatch_num above capacity");

	retire_idle_after_reset : assert property (@(posedge clock)
		$fell(reset) |-> retire_num == 2'd0)
		else $error("retire_num not zero in the first cycle after reset");

	// one store port
	no_store_pair : assert property (@(posedge clock) disable iff (reset)
		retire_num == 2'd2 |-> !(retire[0].wr_mem && retire[1].wr_mem))
		else $error("two stores retired together");

endmodule

bind rob_top rob_top_assertions assertions_inst
(
	.clock        (clock),
	.reset        (reset),
	.dispatch_num (dispatch_num),
	.capacity     (capacity),
	.retire_num   (retire_num),
	.retire       (retire)
);

`default_nettype wire

// ==== testbench/rob_top_tb.sv ====
`default_nettype none

module rob_top_tb;

	import rob_config_pkg::*;
	import rob_pipe_pkg::*;

	localparam int depth = 8;	// small, so wrap and full come quickly
	localparam int lanes = 6;

	typedef struct packed
	{
		issue_count_t retire_num;
		retire_slot_t slot0;
		retire_slot_t slot1;
		logic         halt;
		logic         recover;
		issue_count_t capacity;
	} expected_t;

	logic           clock = 1'b0;
	logic           reset = 1'b1;
	issue_count_t   dispatch_num;
	dispatch_slot_t dispatch [2];
	complete_lane_t complete [lanes];
	issue_count_t   capacity;
	issue_count_t   retire_num;
	retire_slot_t   retire [2];
	logic           retire_halt;
	logic           recover_exception;

	rob_entry_t  model [$];	// in flight, oldest first
	logic [31:0] rng = 32'd64254;
	phys_tag_t   tag_pool = 7'd0;
	int          count_errors = 0;
	int          slot_errors = 0;
	int          flag_errors = 0;
	int          timeout_errors = 0;

	always #4 clock = ~clock;

	rob_top #(.rob_depth(depth), .cdb_lanes(lanes)) rob_top_inst
	(
		.clock             (clock),
		.reset             (reset),
		.dispatch_num      (dispatch_num),
		.dispatch          (dispatch),
		.complete          (complete),
		.capacity          (capacity),
		.retire_num        (retire_num),
		.retire            (retire),
		.retire_halt       (retire_halt),
		.recover_exception (recover_exception)
	);

	////////////////////
	// reference model
	////////////////////

	function automatic issue_count_t model_capacity();
		int free;
		free = depth - model.size();
		return (free >= 2) ? 2'd2 : issue_count_t'(free);
	endfunction

	function automatic expected_t reference_outputs();
		expected_t  e;
		rob_entry_t h;
		rob_entry_t n;
		e = '0;
		h = '0;
		n = '0;
		if (model.size() > 0)
			h = model[0];
		if (model.size() > 1)
			n = model[1];
		if (h.ready && n.ready && !h.exception && !(h.wr_mem && n.wr_mem))
		begin
			e.retire_num = 2'd2;
			e.halt       = h.halt || n.halt;
		end
		else if (h.ready)
		begin
			e.retire_num = 2'd1;	// blocked pair or younger still busy
			e.halt       = h.halt;
		end
		e.recover  = h.ready && (h.exception || (n.ready && n.exception));
		e.slot0    = '{tag: h.tag, arch_reg: h.arch_reg, wr_mem: h.wr_mem};
		e.slot1    = '{tag: n.tag, arch_reg: n.arch_reg, wr_mem: n.wr_mem};
		e.capacity = model_capacity();
		return e;
	endfunction

	function automatic rob_entry_t entry_from(input dispatch_slot_t slot);
		rob_entry_t e;
		e          = '0;
		e.valid    = 1'b1;
		e.ready    = !slot.valid_inst || slot.halt;	// nothing to wait for
		e.halt     = slot.halt;
		e.wr_mem   = slot.wr_mem;
		e.tag      = slot.tag;
		e.arch_reg = slot.arch_reg;
		return e;
	endfunction

	always @(posedge clock)
	begin
		expected_t now;
		now = reference_outputs();	// retirement seen before this edge
		if (reset)
			model.delete();
		else
		begin
			for (int l = 0; l < lanes; l++)	// later lane wins
			begin
				foreach (model[i])
					if (complete[l].valid && model[i].tag == complete[l].tag)
					begin
						model[i].ready     = 1'b1;
						model[i].exception = complete[l].exception;
					end
			end
			for (int i = 0; i < int'(now.retire_num); i++)
				model.delete(0);
			if (dispatch_num != 2'd0)
				model.push_back(entry_from(dispatch[0]));
			if (dispatch_num == 2'd2)
				model.push_back(entry_from(dispatch[1]));
		end
	end

	////////////////////
	// compare
	////////////////////

	task automatic check_count(input string name, input issue_count_t got,
		input issue_count_t want);
		if (got !== want)
		begin
			count_errors++;
			$display("[ERROR] %s is %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_slot(input string name, input retire_slot_t got,
		input retire_slot_t want);
		if (got !== want)
		begin
			slot_errors++;
			$display("[ERROR] %s is %h, expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			flag_errors++;
			$display("[ERROR] %s is %h, expected %h", name, got, want);
		end
	endtask

	// outputs settle after the rising edge
	always @(negedge clock)
	begin
		expected_t want;
		want = reference_outputs();
		if (!reset)
		begin
			check_count("capacity", capacity, want.capacity);
			check_count("retire_num", retire_num, want.retire_num);
			check_flag("retire_halt", retire_halt, want.halt);
			check_flag("recover_exception", recover_exception, want.recover);
			if (want.retire_num != 2'd0)
				check_slot("retire[0]", retire[0], want.slot0);
			if (want.retire_num == 2'd2)
				check_slot("retire[1]", retire[1], want.slot1);
		end
	end

	////////////////////
	// stimulus
	////////////////////

	function automatic logic [31:0] random_word();	// xorshift32
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// rotating tag, unique while in flight
	function automatic dispatch_slot_t new_slot(input logic valid_inst, input logic halt,
		input logic wr_mem);
		dispatch_slot_t s;
		s.tag        = tag_pool;
		s.arch_reg   = arch_reg_t'(random_word());
		s.valid_inst = valid_inst;
		s.halt       = halt;
		s.wr_mem     = wr_mem;
		tag_pool     = (tag_pool == no_tag - 7'd1) ? 7'd0 : tag_pool + 7'd1;
		return s;
	endfunction

	task automatic idle_inputs();
		dispatch_num = 2'd0;
		dispatch[0]  = '0;
		dispatch[1]  = '0;
		for (int l = 0; l < lanes; l++)
			complete[l] = '{valid: 1'b0, tag: no_tag, exception: 1'b0};
	endtask

	task automatic next_cycle();
		@(negedge clock);
		idle_inputs();
	endtask

	task automatic put_dispatch(input issue_count_t num, input dispatch_slot_t s0,
		input dispatch_slot_t s1);
		dispatch_num = num;
		dispatch[0]  = s0;
		dispatch[1]  = s1;
	endtask

	// busy tags in random order on random lanes
	task automatic broadcast(input int fire_percent, input int exc_percent);
		int pending [$];
		int k;
		foreach (model[i])
			if (!model[i].ready)
				pending.push_back(i);
		for (int l = 0; l < lanes; l++)
		begin
			if (pending.size() != 0 && int'(random_word() % 100) < fire_percent)
			begin
				k = int'(random_word() % 32'(pending.size()));
				complete[l] = '{valid: 1'b1, tag: model[pending[k]].tag,
					exception: int'(random_word() % 100) < exc_percent};
				pending.delete(k);
			end
		end
	endtask

	task automatic drain(input int limit);
		int cycles;
		cycles = 0;
		while (model.size() != 0 && cycles < limit)
		begin
			next_cycle();
			broadcast(100, 0);
			cycles++;
		end
		if (model.size() != 0)
		begin
			timeout_errors++;
			$display("buffer still holds %0d entries after %0d cycles", model.size(), limit);
		end
	endtask

	// two real instructions finishing together on an empty buffer
	task automatic pair_test(input logic store0, input logic store1, input logic exc0,
		input logic exc1);
		next_cycle();
		put_dispatch(2'd2, new_slot(1'b1, 1'b0, store0), new_slot(1'b1, 1'b0, store1));
		next_cycle();
		complete[int'(random_word() % 3)] = '{valid: 1'b1, tag: model[0].tag, exception: exc0};
		complete[3 + int'(random_word() % 3)] = '{valid: 1'b1, tag: model[1].tag,
			exception: exc1};
		drain(10);
	endtask

	initial
	begin
		logic [31:0]  r;
		issue_count_t n;
		int           steps;
		idle_inputs();
		repeat (3) @(negedge clock);
		reset = 1'b0;

		// a single first, so capacity passes through 1 on the way to full
		next_cycle();
		put_dispatch(2'd1, new_slot(1'b1, 1'b0, 1'b0), '0);
		steps = 0;
		while (steps < 20)
		begin
			next_cycle();
			if (model_capacity() == 2'd0)
				break;
			put_dispatch(model_capacity(), new_slot(1'b1, 1'b0, 1'b0),
				new_slot(1'b1, 1'b0, 1'b0));
			steps++;
		end
		if (model_capacity() != 2'd0)
		begin
			timeout_errors++;
			$display("buffer did not fill within 20 cycles");
		end
		drain(40);

		// bubbles and halts, ready on entry
		for (int i = 0; i < 8; i++)
		begin
			next_cycle();
			r = random_word();
			put_dispatch(model_capacity(), new_slot(r[0], r[0], 1'b0), new_slot(r[1], r[1], 1'b0));
		end
		drain(10);

		pair_test(1'b1, 1'b1, 1'b0, 1'b0);	// stores go one per cycle
		pair_test(1'b1, 1'b0, 1'b0, 1'b0);
		pair_test(1'b0, 1'b0, 1'b1, 1'b0);	// exceptional head alone
		pair_test(1'b0, 1'b0, 1'b0, 1'b1);

		for (int i = 0; i < 400; i++)
		begin
			next_cycle();
			r = random_word();
			n = issue_count_t'(r % 3);
			if (n > model_capacity())
				n = model_capacity();
			put_dispatch(n, new_slot(r[4:2] != 3'd0, r[8:5] == 4'd0, r[10:9] == 2'd0),
				new_slot(r[13:11] != 3'd0, r[17:14] == 4'd0, r[19:18] == 2'd0));
			broadcast(40, 5);
		end
		drain(60);

		next_cycle();
		@(posedge clock);
		$display("errors: count %0d, retire slot %0d, flag %0d, timeout %0d",
			count_errors, slot_errors, flag_errors, timeout_errors);
		if (count_errors + slot_errors + flag_errors + timeout_errors == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
